// ==== ppu_core.f ====
rtl/ppu_pkg.sv
rtl/ppu_bus_regs.sv
rtl/ppu_timing.sv
rtl/ppu_oam_scan.sv
rtl/ppu_stat_irq.sv
rtl/ppu_core.sv
testbench/tb_clock_gen.sv
testbench/ppu_core_assert.sv
testbench/ppu_core_tb.sv

// ==== testbench/ppu_core_tb.sv ====
`timescale 1ns/1ps

module ppu_core_tb;

  localparam longint DOTS  = longint'(ppu_pkg::DOTS_PER_LINE);
  localparam longint LINES = longint'(ppu_pkg::LINES_PER_FRAME);
  localparam longint FRAME = DOTS * LINES;
  // Edge index of entry to line 144 within a frame
  localparam longint VBL_K = longint'(ppu_pkg::SCREEN_HEIGHT) * DOTS;
  // Reset, one timing frame, up to four for STAT and four for two scan rounds
  localparam longint RUN_CYCLES = 16 + 9 * FRAME + 10000;

  logic        clk;
  logic        reset;
  logic [15:0] addr;
  logic [7:0]  wdata;
  logic        write_en;
  logic        read_en;
  logic [3:0]  sprite_sel;
  logic [7:0]  rdata;
  logic        vblank_req;
  logic        stat_req;
  logic [3:0]  sprite_count;
  logic [7:0]  sprite_y;
  logic [7:0]  sprite_x;
  logic [7:0]  sprite_tile;
  logic [7:0]  sprite_attr;
  logic [5:0]  sprite_oam_idx;

  // Model state
  longint     cyc = 0;
  longint     lcd_base = 0;
  longint     last_write_cyc = 0;
  logic       lcd_active = 1'b0;
  logic       stat_check = 1'b0;
  logic [3:0] ref_en = 4'h0;
  logic [7:0] ref_lyc = 8'h00;
  logic [7:0] oam_model [160];
  int         exp_idx [10];
  int         errors = 0;
  int         vblank_seen = 0;
  int         stat_seen = 0;

  tb_clock_gen #(.PERIOD_NS(40.0)) i_clock_gen (.clk(clk));

  ppu_core i_ppu_core (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .wdata          (wdata),
    .write_en       (write_en),
    .read_en        (read_en),
    .sprite_sel     (sprite_sel),
    .rdata          (rdata),
    .vblank_req     (vblank_req),
    .stat_req       (stat_req),
    .sprite_count   (sprite_count),
    .sprite_y       (sprite_y),
    .sprite_x       (sprite_x),
    .sprite_tile    (sprite_tile),
    .sprite_attr    (sprite_attr),
    .sprite_oam_idx (sprite_oam_idx)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ============================================================
  // Reference model
  // ============================================================

  // Edges since the LCD enable write
  function automatic longint cur_k();
    return cyc - lcd_base;
  endfunction

  function automatic logic [7:0] ref_ly(input longint k);
    return 8'((k / DOTS) % LINES);
  endfunction

  function automatic logic [1:0] ref_mode(input longint k);
    longint d;
    d = k % DOTS;
    if (ref_ly(k) >= 144) return 2'd1;
    if (d < 80) return 2'd2;
    if (d < 252) return 2'd3;
    return 2'd0;
  endfunction

  // Pulse seen at k comes from the change between k-2 and k-1
  function automatic logic exp_stat(input longint k);
    longint     j;
    longint     i;
    logic [1:0] m;
    logic       l_hit;
    logic       m_hit;
    j = (k >= 1) ? k - 1 : 0;
    i = (k >= 2) ? k - 2 : 0;
    m = ref_mode(j);
    l_hit = ref_en[3] && (ref_ly(j) != ref_ly(i)) && (ref_ly(j) == ref_lyc);
    m_hit = (m != ref_mode(i)) && (((m == 2'd2) && ref_en[2]) ||
            ((m == 2'd1) && ref_en[1]) || ((m == 2'd0) && ref_en[0]));
    return l_hit || m_hit;
  endfunction

  // Expected sprite list, fills exp_idx and returns the count
  function automatic int ref_sprites(input int line, input bit tall);
    int n;
    int y;
    int h;
    n = 0;
    h = tall ? 16 : 8;
    for (int e = 0; e < 40; e++) begin
      y = oam_model[e * 4];
      if (n < 10 && line + 16 >= y && line + 16 < y + h) begin
        exp_idx[n] = e;
        n++;
      end
    end
    return n;
  endfunction

  // ============================================================
  // Bus tasks and checks
  // ============================================================

  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    @(posedge clk);
    addr     <= a;
    wdata    <= d;
    write_en <= 1'b1;
    @(posedge clk);
    write_en <= 1'b0;
    #1;
    last_write_cyc = cyc;
  endtask

  task automatic bus_read(input logic [15:0] a, output logic [7:0] d, output longint k);
    @(posedge clk);
    addr    <= a;
    read_en <= 1'b1;
    @(negedge clk);
    d = rdata;
    k = cur_k();
    @(posedge clk);
    read_en <= 1'b0;
  endtask

  task automatic check_val(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %0t %s: got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s: %s (%0d errors)", name,
             (errors == err_start) ? "pass" : "fail", errors - err_start);
  endtask

  task automatic wait_line(input int target);
    do @(negedge clk); while (ref_ly(cur_k()) != target);
  endtask

  // Per-cycle comparison of the interrupt pulses
  always @(negedge clk) begin
    longint k;
    if (lcd_active) begin
      k = cur_k();
      if (vblank_req !== (k > 0 && (k % FRAME) == VBL_K)) begin
        $display("[FAIL] %0t vblank_req %b at dot %0d line %0d", $time, vblank_req,
                 k % DOTS, ref_ly(k));
        errors++;
      end
      if (vblank_req) vblank_seen++;
      if (stat_check && (stat_req !== exp_stat(k))) begin
        $display("[FAIL] %0t stat_req %b at dot %0d line %0d", $time, stat_req,
                 k % DOTS, ref_ly(k));
        errors++;
      end
      if (stat_req) stat_seen++;
    end
  end

  // ============================================================
  // Tests
  // ============================================================

  task automatic scan_round(input bit tall);
    int         line;
    int         n;
    int         h;
    int         e0;
    logic [7:0] b;
    e0 = errors;
    h = tall ? 16 : 8;
    line = $urandom_range(0, 143);
    bus_write(ppu_pkg::REG_LCDC, tall ? 8'h84 : 8'h80);
    for (int a = 0; a < 160; a++) begin
      b = 8'($urandom_range(0, 255));
      // About half land on the chosen line
      if (a % 4 == 0 && $urandom_range(0, 1)) b = 8'(line + 16 - $urandom_range(0, h - 1));
      bus_write(ppu_pkg::OAM_START + 16'(a), b);
      oam_model[a] = b;
    end
    wait_line(144);
    do @(negedge clk); while (!(ref_ly(cur_k()) == line && cur_k() % DOTS == 80));
    n = ref_sprites(line, tall);
    check_val("sprite_count", sprite_count, n);
    for (int s = 0; s < n; s++) begin
      @(posedge clk);
      sprite_sel <= 4'(s);
      @(negedge clk);
      check_val("sprite_oam_idx", sprite_oam_idx, exp_idx[s]);
      check_val("sprite_y", sprite_y, oam_model[exp_idx[s] * 4]);
      check_val("sprite_x", sprite_x, oam_model[exp_idx[s] * 4 + 1]);
      check_val("sprite_tile", sprite_tile, oam_model[exp_idx[s] * 4 + 2]);
      check_val("sprite_attr", sprite_attr, oam_model[exp_idx[s] * 4 + 3]);
    end
    $display("scan line %0d tall %0d hits %0d", line, tall, n);
    if (tall) begin
      report_test("oam scan 8x16", e0);
    end else begin
      report_test("oam scan 8x8", e0);
    end
  endtask

  initial begin
    logic [15:0] regs [10];
    logic [7:0]  vals [10];
    logic [7:0]  d;
    longint      k;
    int          e0;
    int          exp_vbl;
    addr       = 16'h0000;
    wdata      = 8'h00;
    write_en   = 1'b0;
    read_en    = 1'b0;
    sprite_sel = 4'd0;
    reset      = 1'b1;
    void'($urandom(4));
    regs = '{ppu_pkg::REG_LCDC, ppu_pkg::REG_STAT, ppu_pkg::REG_SCY, ppu_pkg::REG_SCX,
             ppu_pkg::REG_LYC, ppu_pkg::REG_BGP, ppu_pkg::REG_OBP0, ppu_pkg::REG_OBP1,
             ppu_pkg::REG_WY, ppu_pkg::REG_WX};
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // Registers, LCD kept off
    e0 = errors;
    foreach (regs[i]) begin
      vals[i] = 8'($urandom_range(0, 255));
      if (i == 0) vals[i][7] = 1'b0;
      bus_write(regs[i], vals[i]);
    end
    ref_en  = vals[1][6:3];
    ref_lyc = vals[4];
    bus_write(ppu_pkg::REG_LY, 8'($urandom_range(1, 255)));
    foreach (regs[i]) begin
      bus_read(regs[i], d, k);
      if (i == 1) check_val("STAT", d, {1'b1, ref_en, ref_lyc == 8'd0, 2'd2});
      else check_val("register", d, vals[i]);
    end
    bus_read(ppu_pkg::REG_LY, d, k);
    check_val("LY", d, 0);
    report_test("registers", e0);

    // OAM fill and VRAM open bus
    e0 = errors;
    for (int a = 0; a < 160; a++) begin
      oam_model[a] = 8'($urandom_range(0, 255));
      bus_write(ppu_pkg::OAM_START + 16'(a), oam_model[a]);
    end
    for (int a = 0; a < 160; a++) begin
      bus_read(ppu_pkg::OAM_START + 16'(a), d, k);
      check_val("OAM", d, oam_model[a]);
    end
    bus_write(16'h8000 + 16'($urandom_range(0, 16'h1FFF)), 8'h12);
    for (int n = 0; n < 8; n++) begin
      bus_read(16'h8000 + 16'($urandom_range(0, 16'h1FFF)), d, k);
      check_val("VRAM", d, 8'hFF);
    end
    report_test("oam", e0);

    // Timing over one frame
    e0 = errors;
    bus_write(ppu_pkg::REG_LCDC, 8'h80);
    lcd_base   = last_write_cyc;
    lcd_active = 1'b1;
    stat_check = 1'b1;
    while (cur_k() < FRAME) begin
      repeat ($urandom_range(1, 1500)) @(posedge clk);
      bus_read(ppu_pkg::REG_STAT, d, k);
      check_val("STAT mode", d[1:0], ref_mode(k));
      check_val("STAT coincidence", d[2], ref_ly(k > 0 ? k - 1 : 0) == ref_lyc);
      bus_read(ppu_pkg::REG_LY, d, k);
      check_val("LY", d, ref_ly(k));
    end
    report_test("timing", e0);

    // STAT sources one at a time
    e0 = errors;
    ref_lyc = 8'($urandom_range(0, 153));
    stat_check = 1'b0;
    bus_write(ppu_pkg::REG_LYC, ref_lyc);
    for (int b = 0; b < 4; b++) begin
      stat_check = 1'b0;
      ref_en = 4'(1 << b);
      bus_write(ppu_pkg::REG_STAT, {1'b0, ref_en, 3'b000});
      repeat (2) @(posedge clk);
      stat_check = 1'b1;
      if (b == 1) begin
        wait_line(0);
        wait_line(145);
      end else if (b == 2) begin
        // Mode 2 entries only happen on visible lines
        wait_line(0);
      end else if (b == 3) begin
        wait_line((ref_lyc + 1) % 154);
        wait_line(ref_lyc);
      end
      repeat (3 * DOTS) @(posedge clk);
    end
    $display("stat pulses seen %0d, lyc %0d", stat_seen, ref_lyc);
    report_test("stat irq", e0);

    // Sprite search in both heights
    scan_round(1'b0);
    scan_round(1'b1);

    k = cur_k();
    exp_vbl = (k >= VBL_K) ? int'((k - VBL_K) / FRAME) + 1 : 0;
    e0 = errors;
    check_val("vblank pulses", vblank_seen, exp_vbl);
    report_test("vblank", e0);

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_CYCLES * 40.0);
    $display("The run timed out before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== testbench/ppu_core_assert.sv ====
`timescale 1ns/1ps

module ppu_core_assert (
  input logic       clk,
  input logic       reset,
  input logic       vblank_req,
  input logic       stat_req,
  input logic       read_en,
  input logic [7:0] rdata
);

  // Requests are single cycle pulses
  vblank_single: assert property (@(posedge clk) disable iff (reset)
    vblank_req |=> !vblank_req)
    else $error("vblank_req high on two consecutive cycles");

  stat_single: assert property (@(posedge clk) disable iff (reset)
    stat_req |=> !stat_req)
    else $error("stat_req high on two consecutive cycles");

  // Idle bus reads as open bus
  idle_bus_ff: assert property (@(posedge clk) disable iff (reset)
    !read_en |-> (rdata == 8'hFF))
    else $error("rdata not FF while read_en low");

endmodule

bind ppu_core ppu_core_assert i_assert (
  .clk        (clk),
  .reset      (reset),
  .vblank_req (vblank_req),
  .stat_req   (stat_req),
  .read_en    (read_en),
  .rdata      (rdata)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk
);

  // Free running, starts low
  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== rtl/ppu_core.sv ====
`timescale 1ns/1ps

module ppu_core (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  input  logic [3:0]  sprite_sel,
  output logic [7:0]  rdata,
  output logic        vblank_req,
  output logic        stat_req,
  output logic [3:0]  sprite_count,
  output logic [7:0]  sprite_y,
  output logic [7:0]  sprite_x,
  output logic [7:0]  sprite_tile,
  output logic [7:0]  sprite_attr,
  output logic [5:0]  sprite_oam_idx
);

  // Register block outputs
  logic        lcd_on;
  logic        obj_tall;
  logic [7:0]  lyc;
  logic [3:0]  stat_enables;
  logic [31:0] oam_entry;

  // Timer outputs
  logic [8:0]  dot;
  logic [7:0]  ly;
  logic [1:0]  mode;

  logic        coincidence;
  logic [5:0]  oam_entry_idx;

  // ============================================================
  // Bus side
  // ============================================================

  ppu_bus_regs i_bus_regs (
    .clk           (clk),
    .reset         (reset),
    .addr          (addr),
    .wdata         (wdata),
    .write_en      (write_en),
    .read_en       (read_en),
    .ly            (ly),
    .mode          (mode),
    .coincidence   (coincidence),
    .oam_entry_idx (oam_entry_idx),
    .rdata         (rdata),
    .lcd_on        (lcd_on),
    .obj_tall      (obj_tall),
    .lyc           (lyc),
    .stat_enables  (stat_enables),
    .oam_entry     (oam_entry)
  );

  // ============================================================
  // Timing and scan
  // ============================================================

  ppu_timing i_timing (
    .clk        (clk),
    .reset      (reset),
    .lcd_on     (lcd_on),
    .dot        (dot),
    .ly         (ly),
    .mode       (mode),
    .vblank_req (vblank_req)
  );

  ppu_oam_scan i_oam_scan (
    .clk            (clk),
    .reset          (reset),
    .dot            (dot),
    .ly             (ly),
    .mode           (mode),
    .obj_tall       (obj_tall),
    .oam_entry      (oam_entry),
    .sprite_sel     (sprite_sel),
    .oam_entry_idx  (oam_entry_idx),
    .sprite_count   (sprite_count),
    .sprite_y       (sprite_y),
    .sprite_x       (sprite_x),
    .sprite_tile    (sprite_tile),
    .sprite_attr    (sprite_attr),
    .sprite_oam_idx (sprite_oam_idx)
  );

  // STAT interrupt
  ppu_stat_irq i_stat_irq (
    .clk          (clk),
    .reset        (reset),
    .ly           (ly),
    .lyc          (lyc),
    .mode         (mode),
    .stat_enables (stat_enables),
    .coincidence  (coincidence),
    .stat_req     (stat_req)
  );

endmodule

// ==== rtl/ppu_stat_irq.sv ====
`timescale 1ns/1ps

module ppu_stat_irq (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] ly,
  input  logic [7:0] lyc,
  input  logic [1:0] mode,
  input  logic [3:0] stat_enables,
  output logic       coincidence,
  output logic       stat_req
);

  logic [7:0] ly_prev;
  logic [1:0] mode_prev;
  logic       lyc_hit;
  logic       mode_hit;

  // Enables map to STAT bits 6..3: LYC, mode 2, mode 1, mode 0
  assign lyc_hit = stat_enables[3] && (ly != ly_prev) && (ly == lyc);

  // Only a fresh mode entry counts
  assign mode_hit = (mode != mode_prev) &&
                    (((mode == ppu_pkg::MODE_OAM) && stat_enables[2]) ||
                     ((mode == ppu_pkg::MODE_VBLANK) && stat_enables[1]) ||
                     ((mode == ppu_pkg::MODE_HBLANK) && stat_enables[0]));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // Match timer reset state, no pulse out of reset
      ly_prev     <= 8'd0;
      mode_prev   <= ppu_pkg::MODE_OAM;
      coincidence <= 1'b0;
      stat_req    <= 1'b0;
    end else begin
      ly_prev     <= ly;
      mode_prev   <= mode;
      coincidence <= (ly == lyc);
      stat_req    <= lyc_hit || mode_hit;
    end
  end

endmodule

// ==== rtl/ppu_oam_scan.sv ====
`timescale 1ns/1ps

module ppu_oam_scan (
  input  logic        clk,
  input  logic        reset,
  input  logic [8:0]  dot,
  input  logic [7:0]  ly,
  input  logic [1:0]  mode,
  input  logic        obj_tall,
  input  logic [31:0] oam_entry,
  input  logic [3:0]  sprite_sel,
  output logic [5:0]  oam_entry_idx,
  output logic [3:0]  sprite_count,
  output logic [7:0]  sprite_y,
  output logic [7:0]  sprite_x,
  output logic [7:0]  sprite_tile,
  output logic [7:0]  sprite_attr,
  output logic [5:0]  sprite_oam_idx
);

  // Sprite list storage
  logic [7:0] list_y    [ppu_pkg::MAX_SPRITES];
  logic [7:0] list_x    [ppu_pkg::MAX_SPRITES];
  logic [7:0] list_tile [ppu_pkg::MAX_SPRITES];
  logic [7:0] list_attr [ppu_pkg::MAX_SPRITES];
  logic [5:0] list_idx  [ppu_pkg::MAX_SPRITES];

  logic [8:0] line_top;
  logic [8:0] height;
  logic [8:0] entry_end;
  logic       hit;
  logic       scan_now;
  logic       take;
  logic       line_done;
  logic [3:0] base_count;
  logic       sel_ok;

  // Two dots per entry
  assign oam_entry_idx = dot[6:1];

  // ============================================================
  // Hit test
  // ============================================================

  // Sprite y is screen line + 16, nine bits so nothing wraps
  assign line_top  = {1'b0, ly} + 9'd16;
  assign height    = obj_tall ? 9'd16 : 9'd8;
  assign entry_end = {1'b0, oam_entry[31:24]} + height;
  assign hit       = (line_top >= {1'b0, oam_entry[31:24]}) && (line_top < entry_end);

  assign scan_now   = (mode == ppu_pkg::MODE_OAM) && !dot[0];
  // Dot 0 always starts a fresh list, also while LCD is off
  assign base_count = (dot == 9'd0) ? 4'd0 : sprite_count;
  assign take       = scan_now && hit && (base_count < ppu_pkg::MAX_SPRITES);

  // Last dot of a line that is followed by a mode 2 line
  assign line_done = (dot == ppu_pkg::DOTS_PER_LINE - 1) &&
                     ((ly == ppu_pkg::LINES_PER_FRAME - 1) ||
                      (ly < ppu_pkg::SCREEN_HEIGHT - 1));

  // ============================================================
  // List update
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sprite_count <= 4'd0;
    end else if (line_done) begin
      sprite_count <= 4'd0;
    end else if (scan_now) begin
      sprite_count <= take ? base_count + 4'd1 : base_count;
    end
  end

  // Hits appended in OAM order
  always_ff @(posedge clk) begin
    if (take) begin
      list_y[base_count]    <= oam_entry[31:24];
      list_x[base_count]    <= oam_entry[23:16];
      list_tile[base_count] <= oam_entry[15:8];
      list_attr[base_count] <= oam_entry[7:0];
      list_idx[base_count]  <= oam_entry_idx;
    end
  end

  // Renderer read port
  assign sel_ok         = sprite_sel < ppu_pkg::MAX_SPRITES;
  assign sprite_y       = sel_ok ? list_y[sprite_sel] : 8'h00;
  assign sprite_x       = sel_ok ? list_x[sprite_sel] : 8'h00;
  assign sprite_tile    = sel_ok ? list_tile[sprite_sel] : 8'h00;
  assign sprite_attr    = sel_ok ? list_attr[sprite_sel] : 8'h00;
  assign sprite_oam_idx = sel_ok ? list_idx[sprite_sel] : 6'd0;

endmodule

// ==== rtl/ppu_timing.sv ====
`timescale 1ns/1ps

module ppu_timing (
  input  logic       clk,
  input  logic       reset,
  input  logic       lcd_on,
  output logic [8:0] dot,
  output logic [7:0] ly,
  output logic [1:0] mode,
  output logic       vblank_req
);

  logic [8:0] dot_next;
  logic [7:0] ly_next;
  logic [1:0] mode_next;
  logic       line_end;

  assign line_end = (dot == ppu_pkg::DOTS_PER_LINE - 1);

  // ============================================================
  // Next dot and line
  // ============================================================

  always_comb begin
    if (!lcd_on) begin
      // LCD off holds the counters at the top of frame
      dot_next = 9'd0;
      ly_next  = 8'd0;
    end else if (line_end) begin
      dot_next = 9'd0;
      // Wrap after line 153
      if (ly == ppu_pkg::LINES_PER_FRAME - 1) begin
        ly_next = 8'd0;
      end else begin
        ly_next = ly + 8'd1;
      end
    end else begin
      dot_next = dot + 9'd1;
      ly_next  = ly;
    end
  end

  // Mode follows the next position, so it flips on the boundary edge
  always_comb begin
    if (ly_next >= ppu_pkg::SCREEN_HEIGHT) begin
      mode_next = ppu_pkg::MODE_VBLANK;
    end else if (dot_next < ppu_pkg::MODE2_LEN) begin
      mode_next = ppu_pkg::MODE_OAM;
    end else if (dot_next < ppu_pkg::MODE2_LEN + ppu_pkg::MODE3_LEN) begin
      mode_next = ppu_pkg::MODE_XFER;
    end else begin
      mode_next = ppu_pkg::MODE_HBLANK;
    end
  end

  // ============================================================
  // State registers
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= 9'd0;
      ly         <= 8'd0;
      mode       <= ppu_pkg::MODE_OAM;
      vblank_req <= 1'b0;
    end else begin
      dot  <= dot_next;
      ly   <= ly_next;
      mode <= mode_next;
      // Single pulse on the edge into line 144
      vblank_req <= lcd_on && line_end && (ly == ppu_pkg::SCREEN_HEIGHT - 1);
    end
  end

endmodule

// ==== rtl/ppu_bus_regs.sv ====
`timescale 1ns/1ps

module ppu_bus_regs (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr,
  input  logic [7:0]  wdata,
  input  logic        write_en,
  input  logic        read_en,
  input  logic [7:0]  ly,
  input  logic [1:0]  mode,
  input  logic        coincidence,
  input  logic [5:0]  oam_entry_idx,
  output logic [7:0]  rdata,
  output logic        lcd_on,
  output logic        obj_tall,
  output logic [7:0]  lyc,
  output logic [3:0]  stat_enables,
  output logic [31:0] oam_entry
);

  // LCD register block
  logic [7:0] lcdc;
  logic [3:0] stat_en;
  logic [7:0] scy;
  logic [7:0] scx;
  logic [7:0] lyc_q;
  logic [7:0] bgp;
  logic [7:0] obp0;
  logic [7:0] obp1;
  logic [7:0] wy;
  logic [7:0] wx;

  logic [7:0] oam [ppu_pkg::OAM_LEN];

  logic       oam_sel;
  logic [7:0] oam_addr;
  logic [7:0] entry_base;

  // ============================================================
  // Address decode
  // ============================================================

  assign oam_sel  = (addr >= ppu_pkg::OAM_START) && (addr <= ppu_pkg::OAM_END);
  // Byte offset into OAM, only meaningful when oam_sel
  assign oam_addr = 8'(addr - ppu_pkg::OAM_START);

  // ============================================================
  // Register writes
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc    <= 8'h00;
      stat_en <= 4'h0;
      scy     <= 8'h00;
      scx     <= 8'h00;
      lyc_q   <= 8'h00;
      bgp     <= 8'h00;
      obp0    <= 8'h00;
      obp1    <= 8'h00;
      wy      <= 8'h00;
      wx      <= 8'h00;
    end else if (write_en) begin
      // LY is read only, FF46 falls to default
      case (addr)
        ppu_pkg::REG_LCDC: lcdc <= wdata;
        ppu_pkg::REG_STAT: stat_en <= wdata[6:3];
        ppu_pkg::REG_SCY:  scy <= wdata;
        ppu_pkg::REG_SCX:  scx <= wdata;
        ppu_pkg::REG_LYC:  lyc_q <= wdata;
        ppu_pkg::REG_BGP:  bgp <= wdata;
        ppu_pkg::REG_OBP0: obp0 <= wdata;
        ppu_pkg::REG_OBP1: obp1 <= wdata;
        ppu_pkg::REG_WY:   wy <= wdata;
        ppu_pkg::REG_WX:   wx <= wdata;
        default: ;
      endcase
    end
  end

  // OAM open to the CPU in every mode
  always_ff @(posedge clk) begin
    if (write_en && oam_sel) begin
      oam[oam_addr] <= wdata;
    end
  end

  // ============================================================
  // CPU readback
  // ============================================================

  always_comb begin
    // Open bus
    rdata = 8'hFF;
    if (read_en) begin
      if (oam_sel) begin
        rdata = oam[oam_addr];
      end else begin
        case (addr)
          ppu_pkg::REG_LCDC: rdata = lcdc;
          // Bit 7 reads as 1
          ppu_pkg::REG_STAT: rdata = {1'b1, stat_en, coincidence, mode};
          ppu_pkg::REG_SCY:  rdata = scy;
          ppu_pkg::REG_SCX:  rdata = scx;
          ppu_pkg::REG_LY:   rdata = ly;
          ppu_pkg::REG_LYC:  rdata = lyc_q;
          ppu_pkg::REG_BGP:  rdata = bgp;
          ppu_pkg::REG_OBP0: rdata = obp0;
          ppu_pkg::REG_OBP1: rdata = obp1;
          ppu_pkg::REG_WY:   rdata = wy;
          ppu_pkg::REG_WX:   rdata = wx;
          // VRAM and everything else unmapped
          default:           rdata = 8'hFF;
        endcase
      end
    end
  end

  // ============================================================
  // Scanner read port
  // ============================================================

  assign entry_base = {oam_entry_idx, 2'b00};

  always_comb begin
    // Index past entry 39 when dot is outside mode 2
    if (entry_base < 8'(ppu_pkg::OAM_LEN)) begin
      oam_entry = {oam[entry_base], oam[entry_base + 8'd1],
                   oam[entry_base + 8'd2], oam[entry_base + 8'd3]};
    end else begin
      oam_entry = 32'h0;
    end
  end

  // Fields used by timing, IRQ and scan
  assign lcd_on       = lcdc[7];
  assign obj_tall     = lcdc[2];
  assign lyc          = lyc_q;
  assign stat_enables = stat_en;

endmodule

// ==== rtl/ppu_pkg.sv ====
package ppu_pkg;

  // ============================================================
  // Line and frame timing
  // ============================================================

  // Dots per scanline, all modes together
  localparam logic [8:0] DOTS_PER_LINE = 9'd456;
  // Visible lines plus ten VBlank lines
  localparam logic [7:0] LINES_PER_FRAME = 8'd154;
  // First VBlank line sits right after this many
  localparam logic [7:0] SCREEN_HEIGHT = 8'd144;

  // Mode lengths inside a visible line
  localparam logic [8:0] MODE2_LEN = 9'd80;
  // Fixed, no renderer to end the transfer early or late
  localparam logic [8:0] MODE3_LEN = 9'd172;

  // ============================================================
  // OAM and sprite list
  // ============================================================

  // Hardware limit per line
  localparam logic [3:0] MAX_SPRITES = 4'd10;
  // 40 entries of y, x, tile, attr
  localparam int OAM_LEN = 160;

  // ============================================================
  // CPU address map
  // ============================================================

  localparam logic [15:0] OAM_START = 16'hFE00;
  localparam logic [15:0] OAM_END = 16'hFE9F;

  // LCD register block, FF46 (DMA) not handled here
  localparam logic [15:0] REG_LCDC = 16'hFF40;
  localparam logic [15:0] REG_STAT = 16'hFF41;
  localparam logic [15:0] REG_SCY = 16'hFF42;
  localparam logic [15:0] REG_SCX = 16'hFF43;
  localparam logic [15:0] REG_LY = 16'hFF44;
  localparam logic [15:0] REG_LYC = 16'hFF45;
  localparam logic [15:0] REG_BGP = 16'hFF47;
  localparam logic [15:0] REG_OBP0 = 16'hFF48;
  localparam logic [15:0] REG_OBP1 = 16'hFF49;
  localparam logic [15:0] REG_WY = 16'hFF4A;
  localparam logic [15:0] REG_WX = 16'hFF4B;

  // ============================================================
  // Mode codes, as seen in STAT[1:0]
  // ============================================================

  localparam logic [1:0] MODE_HBLANK = 2'd0;
  localparam logic [1:0] MODE_VBLANK = 2'd1;
  localparam logic [1:0] MODE_OAM = 2'd2;
  localparam logic [1:0] MODE_XFER = 2'd3;

endpackage
